// ==== hw/ps2_pkg.sv ====
package ps2_pkg;

  // start, 8 data bits, odd parity, stop
  localparam int FRAME_BITS = 11;

  // cycles without a falling ps2 clock before a partial frame is dropped
  localparam logic [15:0] IDLE_LIMIT = 16'd10000;  // ~200 us at 50 MHz

  typedef logic [7:0] scan_code_t;

  typedef enum logic [3:0] {
    key_0     = 4'd0,
    key_1     = 4'd1,
    key_2     = 4'd2,
    key_3     = 4'd3,
    key_4     = 4'd4,
    key_5     = 4'd5,
    key_6     = 4'd6,
    key_7     = 4'd7,
    key_8     = 4'd8,
    key_9     = 4'd9,
    key_add   = 4'd10,
    key_sub   = 4'd11,
    key_enter = 4'd12,
    key_esc   = 4'd13
  } key_code_t;

  localparam scan_code_t BREAK_PREFIX = 8'hF0;  // release marker

  // ************************************************************************
  // set-2 make codes of the keys in use
  localparam scan_code_t SC_0      = 8'h45;
  localparam scan_code_t SC_1      = 8'h16;
  localparam scan_code_t SC_2      = 8'h1E;
  localparam scan_code_t SC_3      = 8'h26;
  localparam scan_code_t SC_4      = 8'h25;
  localparam scan_code_t SC_5      = 8'h2E;
  localparam scan_code_t SC_6      = 8'h36;
  localparam scan_code_t SC_7      = 8'h3D;
  localparam scan_code_t SC_8      = 8'h3E;
  localparam scan_code_t SC_9      = 8'h46;
  localparam scan_code_t SC_ADD    = 8'h79;  // keypad plus
  localparam scan_code_t SC_SUB    = 8'h4E;  // main row minus
  localparam scan_code_t SC_KP_SUB = 8'h7B;  // keypad minus
  localparam scan_code_t SC_ENTER  = 8'h5A;
  localparam scan_code_t SC_ESC    = 8'h76;

  // digit table, index is the digit value
  localparam scan_code_t SC_DIGIT [10] = '{
    SC_0, SC_1, SC_2, SC_3, SC_4, SC_5, SC_6, SC_7, SC_8, SC_9
  };

endpackage

// ==== hw/calc_pkg.sv ====
package calc_pkg;

  typedef logic [3:0] bcd_t;  // one decimal digit

  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1
  } op_t;

  localparam int NUM_DIGITS = 4;     // display width
  localparam int MAG_W      = 14;    // holds 0..9999
  localparam int MAX_MAG    = 9999;  // clamp limit, both signs

  // active low, bit 7 is the decimal point, bits 6..0 are g..a
  typedef logic [7:0] seg_t;

  localparam seg_t SEG_BLANK = 8'hFF;  // all segments dark

  localparam seg_t SEG_DIGIT [10] = '{
    8'hC0,  // 0
    8'hF9,  // 1
    8'hA4,  // 2
    8'hB0,  // 3
    8'h99,  // 4
    8'h92,  // 5
    8'h82,  // 6
    8'hF8,  // 7
    8'h80,  // 8
    8'h90   // 9
  };

endpackage

// ==== hw/ps2_receiver.sv ====
module ps2_receiver import ps2_pkg::*; #(
  parameter int PS2_SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output scan_code_t scan_code,
  output logic       scan_valid
);

  localparam logic [3:0] PAR_IDX  = 4'(FRAME_BITS - 2);  // parity position
  localparam logic [3:0] STOP_IDX = 4'(FRAME_BITS - 1);  // stop position

  logic [PS2_SYNC_STAGES-1:0] clk_sync;   // ps2 clock synchronizer
  logic [PS2_SYNC_STAGES-1:0] data_sync;  // ps2 data synchronizer
  logic                       ps2_clk_s;
  logic                       ps2_data_s;
  logic                       clk_prev;
  logic                       ps2_fall;
  logic [3:0]                 bit_cnt;    // 0 = waiting for start bit
  logic [15:0]                idle_cnt;
  scan_code_t                 shreg;
  logic                       par_bit;
  logic                       frame_ok;

  // ************************************************************************
  // line synchronizers and edge detect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= '1;  // bus idles high
      data_sync <= '1;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[PS2_SYNC_STAGES-2:0], ps2_clk};
      data_sync <= {data_sync[PS2_SYNC_STAGES-2:0], ps2_data};
      clk_prev  <= ps2_clk_s;
    end
  end

  assign ps2_clk_s  = clk_sync[PS2_SYNC_STAGES-1];
  assign ps2_data_s = data_sync[PS2_SYNC_STAGES-1];
  assign ps2_fall   = clk_prev & ~ps2_clk_s;  // device samples here

  // stop bit high and odd parity over data plus parity bit
  assign frame_ok = ps2_data_s & (^{par_bit, shreg});

  // ************************************************************************
  // frame counter, idle watchdog, valid strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      scan_valid <= 1'b0;
    end else begin
      scan_valid <= 1'b0;  // single cycle strobe
      if (ps2_fall) begin
        idle_cnt <= '0;  // bus is alive
        if (bit_cnt == 4'd0) begin
          if (!ps2_data_s) begin
            bit_cnt <= 4'd1;  // valid start bit
          end
        end else if (bit_cnt == STOP_IDX) begin
          bit_cnt    <= '0;
          scan_valid <= frame_ok;  // bad frames vanish silently
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != 4'd0) begin
        if (idle_cnt == IDLE_LIMIT) begin
          bit_cnt  <= '0;  // stalled frame, resync
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 16'd1;
        end
      end
    end
  end

  // ************************************************************************
  // data path
  always_ff @(posedge clk) begin
    if (ps2_fall && bit_cnt >= 4'd1 && bit_cnt < PAR_IDX) begin
      shreg <= {ps2_data_s, shreg[7:1]};  // lsb first
    end
    if (ps2_fall && bit_cnt == PAR_IDX) begin
      par_bit <= ps2_data_s;
    end
    if (ps2_fall && bit_cnt == STOP_IDX && frame_ok) begin
      scan_code <= shreg;  // updates with the strobe
    end
  end

endmodule

// ==== hw/key_decoder.sv ====
module key_decoder import ps2_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  scan_code_t scan_code,
  input  logic       scan_valid,
  output key_code_t  key_code,
  output logic       key_req,
  input  logic       key_ack,
  output key_code_t  last_key
);

  logic      break_pend;  // F0 seen, next code is a release
  logic      map_hit;
  key_code_t map_key;
  logic      xfer_open;
  logic      accept;

  // scan code to key code lookup
  always_comb begin
    map_hit = 1'b1;
    map_key = key_0;
    case (scan_code)
      SC_ADD:            map_key = key_add;
      SC_SUB, SC_KP_SUB: map_key = key_sub;  // either minus key
      SC_ENTER:          map_key = key_enter;
      SC_ESC:            map_key = key_esc;
      default: begin
        map_hit = 1'b0;
        for (int i = 0; i < 10; i++) begin
          if (scan_code == SC_DIGIT[i]) begin
            map_hit = 1'b1;
            map_key = key_code_t'(4'(i));
          end
        end
      end
    endcase
  end

  assign xfer_open = key_req | key_ack;  // busy until ack drops
  assign accept    = scan_valid & map_hit & ~break_pend & ~xfer_open;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      break_pend <= 1'b0;
      key_req    <= 1'b0;
      last_key   <= key_0;
    end else begin
      // break tracking runs even while busy, so a release is never a make
      if (scan_valid) begin
        break_pend <= (scan_code == BREAK_PREFIX);
      end
      if (accept) begin
        key_req  <= 1'b1;     // phase 1
        last_key <= map_key;
      end else if (key_req && key_ack) begin
        key_req <= 1'b0;      // phase 3
      end
    end
  end

  // held stable while req is high
  always_ff @(posedge clk) begin
    if (accept) begin
      key_code <= map_key;
    end
  end

endmodule

// ==== hw/calculator_app.sv ====
module calculator_app import ps2_pkg::*, calc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  key_code_t key_code,
  input  logic      key_req,
  output logic      key_ack,
  output bcd_t      dig0,
  output bcd_t      dig1,
  output bcd_t      dig2,
  output bcd_t      dig3,
  output logic      is_neg
);

  typedef bcd_t [NUM_DIGITS-1:0] bcd_vec_t;  // index 0 is the ones digit

  localparam logic [MAG_W-1:0] PLACE [NUM_DIGITS] = '{14'd1, 14'd10, 14'd100, 14'd1000};

  function automatic logic [MAG_W-1:0] bcd_to_bin(input bcd_vec_t d);
    return MAG_W'(d[3]) * 14'd1000 + MAG_W'(d[2]) * 14'd100
         + MAG_W'(d[1]) * 14'd10 + MAG_W'(d[0]);
  endfunction

  // repeated subtraction, one place after the other
  function automatic bcd_vec_t bin_to_bcd(input logic [MAG_W-1:0] mag);
    bcd_vec_t         d;
    logic [MAG_W-1:0] rem;
    d   = '0;
    rem = mag;
    for (int p = NUM_DIGITS - 1; p >= 0; p--) begin
      for (int k = 0; k < 9; k++) begin
        if (rem >= PLACE[p]) begin
          rem  = rem - PLACE[p];
          d[p] = d[p] + 4'd1;
        end
      end
    end
    return d;
  endfunction

  logic               take;       // one edge per transfer
  logic               is_digit;
  bcd_vec_t           entry_dig;  // digits being typed
  logic [2:0]         entry_cnt;  // 0..4 digits typed
  logic signed [15:0] acc;        // operand a
  op_t                op;
  bcd_vec_t           res_dig;    // last result magnitude
  logic               res_neg;
  logic               show_res;   // result on display, else entry
  logic signed [15:0] opnd_b;
  logic signed [15:0] res_val;
  logic signed [15:0] cur_val;
  logic signed [15:0] sum;
  logic               sum_neg;
  logic [MAG_W-1:0]   sum_mag;

  assign take     = key_req & key_ack;  // req still high, ack just rose
  assign is_digit = (key_code <= key_9);

  // ************************************************************************
  // arithmetic
  assign opnd_b  = 16'(bcd_to_bin(entry_dig));
  assign res_val = res_neg ? -16'(bcd_to_bin(res_dig)) : 16'(bcd_to_bin(res_dig));
  assign cur_val = (entry_cnt == 3'd0) ? res_val : opnd_b;  // chain last result
  assign sum     = (op == op_sub) ? acc - opnd_b : acc + opnd_b;

  always_comb begin
    sum_neg = (sum < 0);
    if (sum > MAX_MAG || sum < -MAX_MAG) begin
      sum_mag = MAG_W'(MAX_MAG);  // clamp
    end else if (sum_neg) begin
      sum_mag = MAG_W'(-sum);
    end else begin
      sum_mag = MAG_W'(sum);
    end
  end

  // ************************************************************************
  // key handling
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_ack   <= 1'b0;
      entry_dig <= '0;
      entry_cnt <= '0;
      acc       <= '0;
      op        <= op_add;
      res_dig   <= '0;
      res_neg   <= 1'b0;
      show_res  <= 1'b0;
    end else begin
      key_ack <= key_req;  // phases 2 and 4
      if (take) begin
        case (key_code)
          key_add, key_sub: begin
            acc       <= cur_val;
            op        <= (key_code == key_sub) ? op_sub : op_add;
            entry_dig <= '0;
            entry_cnt <= '0;
            show_res  <= 1'b0;
          end
          key_enter: begin
            res_dig   <= bin_to_bcd(sum_mag);
            res_neg   <= sum_neg;
            show_res  <= 1'b1;
            acc       <= '0;      // next enter starts from zero
            op        <= op_add;
            entry_dig <= '0;
            entry_cnt <= '0;
          end
          key_esc: begin
            acc       <= '0;
            op        <= op_add;
            res_dig   <= '0;
            res_neg   <= 1'b0;
            show_res  <= 1'b0;
            entry_dig <= '0;
            entry_cnt <= '0;
          end
          default: begin
            if (is_digit && entry_cnt < 3'd4) begin  // fifth digit dropped
              entry_dig <= {entry_dig[NUM_DIGITS-2:0], bcd_t'(key_code)};
              entry_cnt <= entry_cnt + 3'd1;
              show_res  <= 1'b0;
            end
          end
        endcase
      end
    end
  end

  // display source select
  assign dig0   = show_res ? res_dig[0] : entry_dig[0];
  assign dig1   = show_res ? res_dig[1] : entry_dig[1];
  assign dig2   = show_res ? res_dig[2] : entry_dig[2];
  assign dig3   = show_res ? res_dig[3] : entry_dig[3];
  assign is_neg = show_res & res_neg;  // entries are never negative

endmodule

// ==== hw/display_scan.sv ====
module display_scan import calc_pkg::*; #(
  parameter int SCAN_DIV = 50000
) (
  input  logic       clk,
  input  logic       arst_n,
  input  bcd_t       dig0,
  input  bcd_t       dig1,
  input  bcd_t       dig2,
  input  bcd_t       dig3,
  output logic [3:0] ssd_ctl,
  output seg_t       segs
);

  localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;   // cycles within one digit slot
  logic             div_wrap;
  logic             scan_on;   // low during the first period
  logic [1:0]       ptr;       // selected digit
  bcd_t             sel_dig;

  assign div_wrap = (div_cnt == CNT_W'(SCAN_DIV - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      scan_on <= 1'b0;
      ptr     <= 2'd0;
    end else begin
      div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
      if (div_wrap) begin
        scan_on <= 1'b1;
        if (scan_on) begin
          ptr <= ptr + 2'd1;  // dig0 first, wraps after dig3
        end
      end
    end
  end

  // digit mux
  always_comb begin
    case (ptr)
      2'd0:    sel_dig = dig0;
      2'd1:    sel_dig = dig1;
      2'd2:    sel_dig = dig2;
      default: sel_dig = dig3;
    endcase
  end

  // one-hot active low enable, all off until scanning starts
  assign ssd_ctl = scan_on ? ~(4'b0001 << ptr) : 4'b1111;

  // segment encode
  always_comb begin
    segs    = (sel_dig <= 4'd9) ? SEG_DIGIT[sel_dig] : SEG_BLANK;
    segs[7] = 1'b1;  // dp off
  end

endmodule

// ==== hw/keypad_calc_top.sv ====
module keypad_calc_top import ps2_pkg::*, calc_pkg::*; #(
  parameter int SCAN_DIV        = 50000,  // cycles per digit
  parameter int PS2_SYNC_STAGES = 2       // 2 or 3
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [3:0] ssd_ctl,
  output seg_t       segs,
  output logic       is_neg,
  output key_code_t  last_key
);

  scan_code_t scan_code;
  logic       scan_valid;
  key_code_t  key_code;
  logic       key_req;
  logic       key_ack;
  bcd_t       dig0, dig1, dig2, dig3;

  // ************************************************************************
  // keyboard front end
  ps2_receiver #(.PS2_SYNC_STAGES(PS2_SYNC_STAGES)) u_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .scan_valid (scan_valid)  // strobe, no back-pressure
  );

  key_decoder u_kd (
    .clk        (clk),
    .arst_n     (arst_n),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .key_code   (key_code),
    .key_req    (key_req),
    .key_ack    (key_ack),
    .last_key   (last_key)
  );

  // ************************************************************************
  // calculator
  calculator_app u_calc (
    .clk      (clk),
    .arst_n   (arst_n),
    .key_code (key_code),
    .key_req  (key_req),
    .key_ack  (key_ack),  // four-phase with the decoder
    .dig0     (dig0),
    .dig1     (dig1),
    .dig2     (dig2),
    .dig3     (dig3),
    .is_neg   (is_neg)
  );

  // ************************************************************************
  // display
  display_scan #(.SCAN_DIV(SCAN_DIV)) u_disp (
    .clk     (clk),
    .arst_n  (arst_n),
    .dig0    (dig0),
    .dig1    (dig1),
    .dig2    (dig2),
    .dig3    (dig3),
    .ssd_ctl (ssd_ctl),
    .segs    (segs)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD       = 40,  // clk period in time units
  parameter int RESET_CYCLES = 4    // rising edges with reset held
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;  // asserted from time 0
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;  // released on an edge
  end

endmodule

// ==== verification/keypad_calc_tb.sv ====
module keypad_calc_tb import ps2_pkg::*, calc_pkg::*; ();

  localparam int SCAN_DIV      = 4;
  localparam int HALF_BIT      = 8;   // clk cycles per ps2 half bit
  localparam int GAP_CYCLES    = 16;  // idle bus after each frame
  localparam int SETTLE_CYCLES = 16;  // wait before sampling the display
  localparam int N_RAND        = 8;   // random add/sub rounds
  localparam int IDLE_MARGIN   = 64;
  localparam int FRAME_CYCLES  = 11 * (2 * HALF_BIT + 1) + GAP_CYCLES + 1;
  localparam int CHECK_CYCLES  = SETTLE_CYCLES + 4 * SCAN_DIV + 8;
  localparam int KEY_CYCLES    = 3 * FRAME_CYCLES + CHECK_CYCLES;  // make + F0 + code
  // reset, digit entry, random rounds, directed math, framing, escape and chaining
  localparam int MAX_KEYS      = 6 + 10 * N_RAND + 21 + 1 + 18;
  localparam int TEST_CYCLES   = MAX_KEYS * KEY_CYCLES + 2 * (FRAME_CYCLES + CHECK_CYCLES)
                               + int'(IDLE_LIMIT) + IDLE_MARGIN + 16;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

  logic       clk;
  logic       arst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic [3:0] ssd_ctl;
  seg_t       segs;
  logic       is_neg;
  key_code_t  last_key;

  key_code_t   key_log[$];              // every key the DUT should accept
  logic [31:0] lfsr_state = 32'hfb6f;
  int          chk_seq    = 0;          // checks requested
  int          done_seq   = 0;          // checks finished
  int          cycle_cnt  = 0;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  keypad_calc_top #(.SCAN_DIV(SCAN_DIV), .PS2_SYNC_STAGES(2)) dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .ssd_ctl  (ssd_ctl),
    .segs     (segs),
    .is_neg   (is_neg),
    .last_key (last_key)
  );

  // ************************************************************************
  // failure reporting and compares
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_seg(input string name, input seg_t exp, input seg_t act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sign(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_key(input string name, input key_code_t exp, input key_code_t act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %s (%h), got %s (%h)", $time, name,
               exp.name(), exp, act.name(), act);
      abort_run();
    end
  endtask

  // ************************************************************************
  // reference model
  // lit segments as gfedcba, display is active low with dp dark
  function automatic seg_t seg_pattern(input int digit);
    logic [6:0] lit;
    case (digit)
      0:       lit = 7'h3F;
      1:       lit = 7'h06;
      2:       lit = 7'h5B;
      3:       lit = 7'h4F;
      4:       lit = 7'h66;
      5:       lit = 7'h6D;
      6:       lit = 7'h7D;
      7:       lit = 7'h07;
      8:       lit = 7'h7F;
      default: lit = 7'h6F;
    endcase
    return ~{1'b0, lit};
  endfunction

  function automatic void calc_reference(input key_code_t seq[$], output int shown,
                                         output logic neg, output key_code_t last);
    int   entry;
    int   cnt;
    int   acc;
    int   res;
    int   s;
    logic sub;
    logic show;
    entry = 0;
    cnt   = 0;
    acc   = 0;
    res   = 0;
    sub   = 1'b0;
    show  = 1'b0;
    last  = key_0;  // reset value
    foreach (seq[i]) begin
      last = seq[i];
      if (seq[i] <= key_9) begin
        if (cnt < 4) begin  // fifth digit dropped
          entry = entry * 10 + int'(seq[i]);
          cnt++;
          show = 1'b0;
        end
      end else if (seq[i] == key_add || seq[i] == key_sub) begin
        acc   = (cnt == 0) ? res : entry;  // chain last result
        sub   = (seq[i] == key_sub);
        entry = 0;
        cnt   = 0;
        show  = 1'b0;
      end else if (seq[i] == key_enter) begin
        s = sub ? acc - entry : acc + entry;
        if (s > MAX_MAG) s = MAX_MAG;
        else if (s < -MAX_MAG) s = -MAX_MAG;
        res   = s;
        show  = 1'b1;
        acc   = 0;
        sub   = 1'b0;
        entry = 0;
        cnt   = 0;
      end else begin  // escape
        entry = 0;
        cnt   = 0;
        acc   = 0;
        res   = 0;
        sub   = 1'b0;
        show  = 1'b0;
      end
    end
    shown = show ? ((res < 0) ? -res : res) : entry;
    neg   = show && (res < 0);
  endfunction

  // active low one-hot to digit index, -1 when not one-hot
  function automatic int ctl_index(input logic [3:0] c);
    case (c)
      4'b1110: return 0;
      4'b1101: return 1;
      4'b1011: return 2;
      4'b0111: return 3;
      default: return -1;
    endcase
  endfunction

  // ************************************************************************
  // compare process
  task automatic run_display_check();
    int        shown;
    logic      neg;
    key_code_t last;
    int        pos;
    int        digit;
    logic [3:0] seen;
    calc_reference(key_log, shown, neg, last);
    seen = 4'b0000;
    repeat (SETTLE_CYCLES) @(posedge clk);
    repeat (4 * SCAN_DIV) begin  // one full scan
      @(negedge clk);
      pos = ctl_index(ssd_ctl);
      if (pos < 0) begin
        $display("ssd_ctl is %b at %0t, which does not select exactly one digit",
                 ssd_ctl, $time);
        abort_run();
      end
      seen[pos] = 1'b1;
      digit = shown;
      for (int p = 0; p < pos; p++) begin
        digit = digit / 10;
      end
      check_seg($sformatf("segs(digit %0d)", pos), seg_pattern(digit % 10), segs);
    end
    if (seen != 4'b1111) begin
      $display("not every digit position was selected during one scan");
      abort_run();
    end
    check_sign("is_neg", neg, is_neg);
    check_key("last_key", last, last_key);
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (done_seq != chk_seq) begin
        run_display_check();
        done_seq = chk_seq;
      end
    end
  end

  // ************************************************************************
  // stimulus helpers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, right shift
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    repeat (n) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);  // one step per bit
    end
  endtask

  function automatic scan_code_t make_code(input key_code_t k);
    case (k)
      key_add:   return SC_ADD;
      key_sub:   return SC_SUB;
      key_enter: return SC_ENTER;
      key_esc:   return SC_ESC;
      default:   return SC_DIGIT[int'(k)];
    endcase
  endfunction

  // start, data lsb first, parity, stop; nbits < 11 leaves a partial frame
  task automatic send_frame(input scan_code_t code, input logic bad_parity, input int nbits);
    logic [10:0] bits;
    bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      @(posedge clk);
      ps2_data <= bits[i];
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b0;  // device clock falls, receiver samples
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    @(posedge clk);
    ps2_data <= 1'b1;  // bus idle
    repeat (GAP_CYCLES) @(posedge clk);
  endtask

  task automatic request_check();
    chk_seq++;
    while (done_seq != chk_seq) @(posedge clk);
  endtask

  // make, then release as F0 plus the same code
  task automatic press_scan(input scan_code_t sc, input key_code_t k);
    send_frame(sc, 1'b0, 11);            // make
    send_frame(BREAK_PREFIX, 1'b0, 11);  // release
    send_frame(sc, 1'b0, 11);
    key_log.push_back(k);
    request_check();
  endtask

  task automatic press_key(input key_code_t k);
    press_scan(make_code(k), k);
  endtask

  task automatic type_number(input int value);
    int div;
    div = 1000;
    while (div > 1 && value < div) div = div / 10;
    while (div > 0) begin
      press_key(key_code_t'(4'((value / div) % 10)));
      div = div / 10;
    end
  endtask

  task automatic type_random_operand();
    int ndig;
    int d;
    take_bits(2, ndig);  // 1..4 digits
    for (int i = 0; i <= ndig; i++) begin
      take_bits(4, d);
      press_key(key_code_t'(4'(d % 10)));
    end
  endtask

  // ************************************************************************
  // test sequence
  initial begin
    int b;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    @(posedge arst_n);
    @(negedge clk);
    if (ssd_ctl !== 4'b1111) begin
      $display("ssd_ctl enabled a digit before the first scan period ended");
      abort_run();
    end
    request_check();  // all zeros after reset

    for (int i = 1; i <= 5; i++) begin  // fifth digit is ignored
      press_key(key_code_t'(4'(i)));
    end
    press_key(key_esc);

    for (int r = 0; r < N_RAND; r++) begin
      type_random_operand();
      take_bits(1, b);
      press_key(b != 0 ? key_sub : key_add);
      type_random_operand();
      press_key(key_enter);
    end
    type_number(5);     // negative result
    press_key(key_sub);
    type_number(9999);
    press_key(key_enter);
    press_key(key_sub);  // chained, clamps at -9999
    type_number(50);
    press_key(key_enter);
    type_number(9000);  // clamps at +9999
    press_key(key_add);
    type_number(5000);
    press_key(key_enter);

    send_frame(SC_7, 1'b1, 11);  // bad parity
    request_check();
    send_frame(SC_7, 1'b0, 4);   // stalled frame
    repeat (int'(IDLE_LIMIT) + IDLE_MARGIN) @(posedge clk);
    press_key(key_3);

    press_key(key_esc);
    type_number(8);
    press_key(key_sub);
    type_number(9);
    press_key(key_enter);
    press_key(key_esc);  // sign and digits cleared
    type_number(20);
    press_key(key_add);
    type_number(5);
    press_key(key_enter);
    press_key(key_add);  // result chains in
    type_number(5);
    press_key(key_enter);
    press_scan(SC_KP_SUB, key_sub);  // keypad minus
    type_number(40);
    press_key(key_enter);

    $display("All tests passed!");
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

endmodule

// ==== sources.f ====
hw/ps2_pkg.sv
hw/calc_pkg.sv
hw/ps2_receiver.sv
hw/key_decoder.sv
hw/calculator_app.sv
hw/display_scan.sv
hw/keypad_calc_top.sv
verification/tb_clock_gen.sv
verification/keypad_calc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module keypad_calc_tb \
  -f sources.f \
  -Mdir obj_dir -o keypad_calc_sim

./obj_dir/keypad_calc_sim
